// File: hw/syscfg_pkg.sv
`default_nettype none

package syscfg_pkg;

    // **************************************************
    // Sizes and address map
    // **************************************************

    localparam int NO_TGTS    = 4;
    localparam int NO_IRQS    = 8;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    localparam int TGT_WINDOW = 16;                        // Bytes per target window
    localparam int OFS_W      = $clog2(TGT_WINDOW);
    localparam int TGT_IDX_W  = $clog2(NO_TGTS);
    localparam int MAP_W      = OFS_W + TGT_IDX_W;         // Map covers bytes 0 to 63

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Register offsets inside one target window
    typedef enum logic [OFS_W-1:0] {
        REG_CTRL      = 4'd0,
        REG_STATUS    = 4'd4,                              // Read only
        REG_BOOT_ADDR = 4'd8,
        REG_IRQ_MASK  = 4'd12
    } reg_offset_e;

    localparam int CTRL_RST_BIT   = 0;
    localparam int CTRL_PAUSE_BIT = 1;
    localparam int STAT_RST_BIT   = 0;
    localparam int STAT_ACK_BIT   = 1;

    localparam addr_t BOOT_ADDR_RESET = 32'h0000_1000;

    // **************************************************
    // Bus and target types
    // **************************************************

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        data_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic  rst;                                        // High holds the target in reset
        logic  pause;
        addr_t boot_addr;
        logic  irq;
    } tgt_out_t;

    typedef struct packed {
        logic bootstrap;                                   // Leaves reset on its own
        logic en_boot_addr;
        logic en_irq;
    } tgt_cfg_t;

    // Two power domains, one CPU, one DMA engine
    localparam tgt_cfg_t TGT_CFG [NO_TGTS] = '{
        '{bootstrap: 1'b1, en_boot_addr: 1'b0, en_irq: 1'b0},
        '{bootstrap: 1'b1, en_boot_addr: 1'b0, en_irq: 1'b0},
        '{bootstrap: 1'b0, en_boot_addr: 1'b1, en_irq: 1'b1},
        '{bootstrap: 1'b0, en_boot_addr: 1'b0, en_irq: 1'b1}
    };

    typedef enum logic [1:0] {
        PS_IDLE,
        PS_PAUSING,
        PS_PAUSED,
        PS_RELEASING
    } pause_state_e;

endpackage

`default_nettype wire

// File: hw/syscfg_apb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module syscfg_apb_decoder import syscfg_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    input  apb_req_t req,
    output apb_rsp_t rsp,

    output apb_req_t tgt_req [NO_TGTS],
    input  apb_rsp_t tgt_rsp [NO_TGTS]
);

    logic [TGT_IDX_W-1:0] addr_idx;
    logic                 addr_err;
    logic [TGT_IDX_W-1:0] idx_q;
    logic                 err_q;
    logic [TGT_IDX_W-1:0] sel_idx;
    logic                 sel_err;
    logic                 setup;
    logic                 access;

    assign addr_idx = req.paddr[MAP_W-1:OFS_W];
    assign addr_err = |req.paddr[ADDR_WIDTH-1:MAP_W];      // Beyond the last window

    assign setup  = req.psel && !req.penable;
    assign access = req.psel && req.penable;

    // **************************************************
    // Hold the decode across the transfer
    // **************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx_q <= '0;
            err_q <= 1'b0;
        end else if (setup) begin
            idx_q <= addr_idx;
            err_q <= addr_err;
        end
    end

    // Live decode in setup, held decode in access
    assign sel_idx = req.penable ? idx_q : addr_idx;
    assign sel_err = req.penable ? err_q : addr_err;

    always_comb begin
        for (int i = 0; i < NO_TGTS; i++) begin
            tgt_req[i]      = req;
            tgt_req[i].psel = req.psel && !sel_err && (sel_idx == TGT_IDX_W'(i));
        end
    end

    // **************************************************
    // Response path
    // **************************************************

    always_comb begin
        if (sel_err) begin
            rsp.prdata  = '0;
            rsp.pready  = access;
            rsp.pslverr = access;                          // Out-of-map error
        end else begin
            rsp = tgt_rsp[sel_idx];
        end
    end

endmodule

`default_nettype wire

// File: hw/syscfg_tgt.sv
`timescale 1ns/1ps
`default_nettype none

module syscfg_tgt import syscfg_pkg::*; #(
    parameter tgt_cfg_t CFG = '0
) (
    input  logic               clk,
    input  logic               rst_n,

    input  apb_req_t           req,
    output apb_rsp_t           rsp,

    input  logic               seq_pause,
    input  logic               pause_ack,
    input  logic [NO_IRQS-1:0] irq_vec,

    output tgt_out_t           tgt_out
);

    reg_offset_e        offset;
    logic               access;
    logic               wr_en;
    logic               rd_en;
    data_t              rd_data;

    logic               ctrl_rst_q;
    logic               ctrl_pause_q;
    addr_t              boot_addr_q;
    logic [NO_IRQS-1:0] irq_mask_q;

    assign offset = reg_offset_e'(req.paddr[OFS_W-1:0]);
    assign access = req.psel && req.penable;
    assign wr_en  = access && req.pwrite;
    assign rd_en  = access && !req.pwrite;

    // **************************************************
    // Register writes
    // **************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_rst_q   <= !CFG.bootstrap;                // Bootstrap targets start running
            ctrl_pause_q <= 1'b0;
            boot_addr_q  <= BOOT_ADDR_RESET;
            irq_mask_q   <= '0;
        end else if (wr_en) begin
            case (offset)
                REG_CTRL: begin
                    ctrl_rst_q   <= req.pwdata[CTRL_RST_BIT];
                    ctrl_pause_q <= req.pwdata[CTRL_PAUSE_BIT];
                end
                REG_BOOT_ADDR: begin
                    if (CFG.en_boot_addr) begin
                        boot_addr_q <= req.pwdata;
                    end
                end
                REG_IRQ_MASK: begin
                    if (CFG.en_irq) begin
                        irq_mask_q <= req.pwdata[NO_IRQS-1:0];
                    end
                end
                default: begin
                end                                        // STATUS and holes ignore writes
            endcase
        end
    end

    // **************************************************
    // Register reads
    // **************************************************

    always_comb begin
        rd_data = '0;
        case (offset)
            REG_CTRL: begin
                rd_data[CTRL_RST_BIT]   = ctrl_rst_q;
                rd_data[CTRL_PAUSE_BIT] = ctrl_pause_q;
            end
            REG_STATUS: begin
                rd_data[STAT_RST_BIT] = ctrl_rst_q;
                rd_data[STAT_ACK_BIT] = pause_ack;         // Live device acknowledge
            end
            REG_BOOT_ADDR: begin
                if (CFG.en_boot_addr) begin
                    rd_data = boot_addr_q;
                end
            end
            REG_IRQ_MASK: begin
                if (CFG.en_irq) begin
                    rd_data[NO_IRQS-1:0] = irq_mask_q;
                end
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    assign rsp.prdata  = rd_en ? rd_data : '0;
    assign rsp.pready  = access;                           // Zero wait states
    assign rsp.pslverr = 1'b0;

    // **************************************************
    // Target outputs
    // **************************************************

    assign tgt_out.rst       = ctrl_rst_q;
    assign tgt_out.pause     = ctrl_pause_q || seq_pause;
    assign tgt_out.boot_addr = CFG.en_boot_addr ? boot_addr_q : '0;
    assign tgt_out.irq       = CFG.en_irq && |(irq_vec & irq_mask_q);

endmodule

`default_nettype wire

// File: hw/syscfg_pause_seq.sv
`timescale 1ns/1ps
`default_nettype none

module syscfg_pause_seq import syscfg_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               pause_req,
    output logic               pause_ack,

    output logic [NO_TGTS-1:0] tgt_pause,
    input  logic [NO_TGTS-1:0] tgt_ack
);

    pause_state_e         state_q;
    logic [TGT_IDX_W-1:0] idx_q;
    logic [TGT_IDX_W-1:0] idx_nxt;
    logic [NO_TGTS-1:0]   pause_q;
    logic                 ack_q;
    logic                 last_tgt;

    assign idx_nxt  = idx_q + TGT_IDX_W'(1);
    assign last_tgt = (idx_q == TGT_IDX_W'(NO_TGTS - 1));

    // **************************************************
    // Serial pause FSM
    // **************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= PS_IDLE;
            idx_q   <= '0;
            pause_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            case (state_q)
                PS_IDLE: begin
                    if (pause_req) begin
                        idx_q      <= '0;
                        pause_q[0] <= 1'b1;                // Start with target 0
                        state_q    <= PS_PAUSING;
                    end
                end
                PS_PAUSING: begin
                    if (!pause_req) begin
                        pause_q <= '0;                     // Abort releases what was paused
                        state_q <= PS_RELEASING;
                    end else if (tgt_ack[idx_q]) begin
                        if (last_tgt) begin
                            ack_q   <= 1'b1;
                            state_q <= PS_PAUSED;
                        end else begin
                            idx_q            <= idx_nxt;
                            pause_q[idx_nxt] <= 1'b1;
                        end
                    end
                end
                PS_PAUSED: begin
                    if (!pause_req) begin
                        pause_q <= '0;                     // All released at once
                        state_q <= PS_RELEASING;
                    end
                end
                PS_RELEASING: begin
                    if (tgt_ack == '0) begin
                        ack_q   <= 1'b0;
                        state_q <= PS_IDLE;
                    end
                end
                default: begin
                    state_q <= PS_IDLE;
                end
            endcase
        end
    end

    assign tgt_pause = pause_q;
    assign pause_ack = ack_q;

endmodule

`default_nettype wire

// File: hw/syscfg_top.sv
`timescale 1ns/1ps
`default_nettype none

module syscfg_top import syscfg_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,

    input  apb_req_t           apb_req,
    output apb_rsp_t           apb_rsp,

    input  logic [NO_IRQS-1:0] irq_vec,

    input  logic               pause_req,
    output logic               pause_ack,

    input  logic [NO_TGTS-1:0] tgt_pause_ack,
    output tgt_out_t           tgt_out [NO_TGTS]
);

    apb_req_t           tgt_req [NO_TGTS];
    apb_rsp_t           tgt_rsp [NO_TGTS];
    logic [NO_TGTS-1:0] seq_pause;
    logic [NO_TGTS-1:0] seq_ack;

    // **************************************************
    // APB decode and pause sequencing
    // **************************************************

    syscfg_apb_decoder u_decoder (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (apb_req),
        .rsp     (apb_rsp),
        .tgt_req (tgt_req),
        .tgt_rsp (tgt_rsp)
    );

    syscfg_pause_seq u_pause_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .tgt_pause (seq_pause),
        .tgt_ack   (seq_ack)
    );

    // **************************************************
    // One register block per target
    // **************************************************

    for (genvar i = 0; i < NO_TGTS; i++) begin : g_tgt
        // An ack still held by the CTRL pause bit counts as released
        assign seq_ack[i] = tgt_pause_ack[i] && (seq_pause[i] || !tgt_out[i].pause);

        syscfg_tgt #(
            .CFG (TGT_CFG[i])
        ) u_tgt (
            .clk       (clk),
            .rst_n     (rst_n),
            .req       (tgt_req[i]),
            .rsp       (tgt_rsp[i]),
            .seq_pause (seq_pause[i]),
            .pause_ack (tgt_pause_ack[i]),
            .irq_vec   (irq_vec),
            .tgt_out   (tgt_out[i])
        );
    end

endmodule

`default_nettype wire

// File: verification/syscfg_tb.sv
`timescale 1ns/1ps
`default_nettype none

module syscfg_tb import syscfg_pkg::*; ();

    localparam int N_TRAFFIC = 300;
    localparam int N_OOM     = 20;
    localparam int N_IRQ     = 10;
    localparam int N_ROUNDS  = 8;
    localparam int N_XFERS   = 32 + N_TRAFFIC + N_OOM + (N_IRQ + 3 * N_ROUNDS) * NO_TGTS;
    localparam int WATCHDOG_CYCLES = 16 + N_XFERS * 4 + N_ROUNDS * 200;

    logic                    clk = 1'b0;
    logic                    rst_n = 1'b0;
    apb_req_t                apb_req = '0;
    apb_rsp_t                apb_rsp;
    logic [NO_IRQS-1:0]      irq_vec = '0;
    logic                    pause_req = 1'b0;
    logic                    pause_ack;
    logic [NO_TGTS-1:0]      tgt_pause_ack = '0;
    tgt_out_t                tgt_out [NO_TGTS];

    logic [31:0]             stim_lfsr = 32'd66;
    logic [31:0]             dev_lfsr = 32'd66;
    logic [NO_TGTS-1:0]      armed = '0;
    logic [NO_TGTS-1:0][2:0] delay;
    logic                    ack_seen = 1'b0;
    string                   phase = "reset";

    // Shadow registers of the reference model
    logic                    m_rst   [NO_TGTS];
    logic                    m_pause [NO_TGTS];
    addr_t                   m_boot  [NO_TGTS];
    logic [NO_IRQS-1:0]      m_mask  [NO_TGTS];

    always #50 clk = ~clk;

    syscfg_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .irq_vec       (irq_vec),
        .pause_req     (pause_req),
        .pause_ack     (pause_ack),
        .tgt_pause_ack (tgt_pause_ack),
        .tgt_out       (tgt_out)
    );

    // **************************************************
    // Checking helpers
    // **************************************************

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t ns: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic compare_rsp(input string name, input apb_rsp_t got, input apb_rsp_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t ns: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic compare_tgt(input string name, input tgt_out_t got, input tgt_out_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t ns: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] lfsr_bits(inout logic [31:0] state, input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
            val   = {val[30:0], state[0]};
        end
        return val;
    endfunction

    function automatic data_t exp_read(input int t, input logic [3:0] ofs, input logic ack);
        data_t d;
        d = '0;
        case (ofs)
            REG_CTRL: begin
                d[CTRL_RST_BIT]   = m_rst[t];
                d[CTRL_PAUSE_BIT] = m_pause[t];
            end
            REG_STATUS: begin
                d[STAT_RST_BIT] = m_rst[t];
                d[STAT_ACK_BIT] = ack;
            end
            REG_BOOT_ADDR: d = TGT_CFG[t].en_boot_addr ? m_boot[t] : '0;
            REG_IRQ_MASK: d[NO_IRQS-1:0] = TGT_CFG[t].en_irq ? m_mask[t] : '0;
            default: d = '0;                               // Holes read 0
        endcase
        return d;
    endfunction

    function automatic tgt_out_t exp_tgt(input int t, input logic seq_on);
        tgt_out_t e;
        e.rst       = m_rst[t];
        e.pause     = m_pause[t] || seq_on;
        e.boot_addr = TGT_CFG[t].en_boot_addr ? m_boot[t] : '0;
        e.irq       = TGT_CFG[t].en_irq && (|(irq_vec & m_mask[t]));
        return e;
    endfunction

    task automatic check_outputs(input logic seq_on);
        for (int i = 0; i < NO_TGTS; i++) begin
            compare_tgt($sformatf("tgt_out[%0d]", i), tgt_out[i], exp_tgt(i, seq_on));
        end
    endtask

    // **************************************************
    // APB driver
    // **************************************************

    task automatic apb_xfer(input logic wr, input addr_t addr, input data_t wdata,
                            output apb_rsp_t rsp, output logic [NO_TGTS-1:0] ack_at);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(negedge clk);
        compare_rsp("apb_rsp in setup", apb_rsp, '0);      // No pready before access
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rsp    = apb_rsp;
        ack_at = tgt_pause_ack;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic do_write(input int t, input logic [3:0] ofs, input data_t wdata);
        apb_rsp_t           rsp;
        logic [NO_TGTS-1:0] ack_at;
        apb_xfer(1'b1, addr_t'(t * TGT_WINDOW + int'(ofs)), wdata, rsp, ack_at);
        compare_rsp("apb_rsp write", rsp, '{prdata: '0, pready: 1'b1, pslverr: 1'b0});
        case (ofs)
            REG_CTRL: begin
                m_rst[t]   = wdata[CTRL_RST_BIT];
                m_pause[t] = wdata[CTRL_PAUSE_BIT];
            end
            REG_BOOT_ADDR: if (TGT_CFG[t].en_boot_addr) m_boot[t] = wdata;
            REG_IRQ_MASK: if (TGT_CFG[t].en_irq) m_mask[t] = wdata[NO_IRQS-1:0];
            default: ;
        endcase
        @(negedge clk);
        check_outputs(1'b0);
    endtask

    task automatic do_read(input int t, input logic [3:0] ofs);
        apb_rsp_t           rsp;
        logic [NO_TGTS-1:0] ack_at;
        data_t              exp;
        apb_xfer(1'b0, addr_t'(t * TGT_WINDOW + int'(ofs)), '0, rsp, ack_at);
        exp = exp_read(t, ofs, ack_at[t]);
        compare_data($sformatf("prdata tgt %0d ofs %0d", t, ofs), rsp.prdata, exp);
        compare_rsp("apb_rsp read", rsp, '{prdata: exp, pready: 1'b1, pslverr: 1'b0});
    endtask

    task automatic read_all_regs();
        for (int i = 0; i < NO_TGTS; i++) begin
            for (int r = 0; r < 4; r++) begin
                do_read(i, 4'(r * 4));
            end
        end
    endtask

    task automatic wait_pause_ack(input logic value);
        do begin
            @(negedge clk);
        end while (pause_ack !== value);
    endtask

    // **************************************************
    // Device models and pause monitor
    // **************************************************

    always @(posedge clk) begin
        for (int i = 0; i < NO_TGTS; i++) begin
            if (!rst_n) begin
                tgt_pause_ack[i] <= 1'b0;
                armed[i]         <= 1'b0;
            end else if (tgt_out[i].pause == tgt_pause_ack[i]) begin
                armed[i] <= 1'b0;
            end else if (!armed[i]) begin
                armed[i] <= 1'b1;
                delay[i] <= 3'(lfsr_bits(dev_lfsr, 3));    // 0 to 7 cycles
            end else if (delay[i] == 3'd0) begin
                tgt_pause_ack[i] <= tgt_out[i].pause;
                armed[i]         <= 1'b0;
            end else begin
                delay[i] <= delay[i] - 3'd1;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (pause_ack && !ack_seen && !pause_req) begin
                report_failure("pause_ack rose without a pause request");
            end
            for (int i = 0; i < NO_TGTS; i++) begin
                if (m_pause[i] && !tgt_out[i].pause) begin
                    report_failure($sformatf("target %0d lost its CTRL pause", i));
                end
                if (tgt_out[i].pause && !m_pause[i]) begin
                    for (int j = 0; j < i; j++) begin
                        if (!tgt_pause_ack[j]) begin
                            report_failure($sformatf("target %0d paused before %0d acked", i, j));
                        end
                    end
                end
                if (pause_ack && pause_req && !(tgt_out[i].pause && tgt_pause_ack[i])) begin
                    report_failure($sformatf("pause_ack high but target %0d not paused", i));
                end
                if (ack_seen && !pause_ack && !m_pause[i] && tgt_pause_ack[i]) begin
                    report_failure($sformatf("pause_ack fell while target %0d still acks", i));
                end
            end
            ack_seen <= pause_ack;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout in phase %s after %0d cycles", phase, WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // **************************************************
    // Test sequence
    // **************************************************

    initial begin
        int                 t;
        logic [3:0]         ofs;
        data_t              wdata;
        addr_t              addr;
        apb_rsp_t           rsp;
        logic [NO_TGTS-1:0] ack_at;

        for (int i = 0; i < NO_TGTS; i++) begin
            m_rst[i]   = !TGT_CFG[i].bootstrap;
            m_pause[i] = 1'b0;
            m_boot[i]  = BOOT_ADDR_RESET;
            m_mask[i]  = '0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_outputs(1'b0);
        read_all_regs();

        phase = "register traffic";
        for (int n = 0; n < N_TRAFFIC; n++) begin
            t = int'(lfsr_bits(stim_lfsr, 2));
            if (lfsr_bits(stim_lfsr, 3) == 32'd0) begin
                ofs = 4'(lfsr_bits(stim_lfsr, 4));         // Mostly aligned, some holes
            end else begin
                ofs = {2'(lfsr_bits(stim_lfsr, 2)), 2'b00};
            end
            wdata = lfsr_bits(stim_lfsr, 32);
            if (lfsr_bits(stim_lfsr, 1) != 32'd0) begin
                do_write(t, ofs, wdata);
            end else begin
                do_read(t, ofs);
            end
        end

        phase = "out-of-map";
        for (int n = 0; n < N_OOM; n++) begin
            addr = lfsr_bits(stim_lfsr, 32);
            if (addr < 32'd64) begin
                addr = addr + 32'd64;
            end
            wdata = lfsr_bits(stim_lfsr, 32);
            apb_xfer(1'(lfsr_bits(stim_lfsr, 1)), addr, wdata, rsp, ack_at);
            compare_rsp("apb_rsp out-of-map", rsp, '{prdata: '0, pready: 1'b1, pslverr: 1'b1});
            @(negedge clk);
            check_outputs(1'b0);
        end
        read_all_regs();

        phase = "interrupt masking";
        for (int n = 0; n < N_IRQ; n++) begin
            for (int i = 0; i < NO_TGTS; i++) begin
                do_write(i, REG_IRQ_MASK, lfsr_bits(stim_lfsr, 32));
            end
            @(posedge clk);
            irq_vec <= NO_IRQS'(lfsr_bits(stim_lfsr, NO_IRQS));
            @(negedge clk);
            check_outputs(1'b0);
        end

        phase = "global pause";
        for (int r = 0; r < N_ROUNDS; r++) begin
            for (int i = 0; i < NO_TGTS; i++) begin
                wdata = lfsr_bits(stim_lfsr, 32);
                wdata[CTRL_PAUSE_BIT] = (lfsr_bits(stim_lfsr, 2) == 32'd0);
                do_write(i, REG_CTRL, wdata);
            end
            @(posedge clk);
            pause_req <= 1'b1;
            wait_pause_ack(1'b1);
            check_outputs(1'b1);
            for (int i = 0; i < NO_TGTS; i++) begin
                do_read(i, REG_STATUS);
            end
            @(posedge clk);
            pause_req <= 1'b0;
            wait_pause_ack(1'b0);
            check_outputs(1'b0);
            for (int i = 0; i < NO_TGTS; i++) begin
                do_read(i, REG_STATUS);
            end
        end

        phase = "done";
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/syscfg_pkg.sv
hw/syscfg_apb_decoder.sv
hw/syscfg_tgt.sv
hw/syscfg_pause_seq.sv
hw/syscfg_top.sv
verification/syscfg_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the syscfg testbench with Verilator
set -e

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --top-module syscfg_tb -Mdir obj_dir -f compile.f

# The log decides the result
./obj_dir/Vsyscfg_tb 2>&1 | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "syscfg testbench reported a failure, see $LOG"
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "syscfg testbench ended without a result, see $LOG"
    exit 1
fi
echo "syscfg testbench finished cleanly"
